/* rtl/pmp_pkg.sv */
// PMP shared definitions
package pmp_pkg;

    // Physical address width.
    localparam int ADDR_W = 32;

    // Ignored low address bits.
    // Two allows NA4 regions.
    localparam int GRAIN = 2;

    // Number of PMP entries.
    localparam int DEPTH = 16;

    // Number of independent access-check ports.
    localparam int CHECKERS = 2;

    // Stored cfg bits per entry.
    // Bits 2..0 are x, w, r and bits 4..3 the matching mode.
    localparam int CFG_W = 5;

    // Stored address bits per entry, address bits ADDR_W-1 down to GRAIN.
    localparam int ENTRY_AW = ADDR_W - GRAIN;

    // Word-granular address width seen by the check ports.
    localparam int CHECK_AW = ADDR_W - 2;

    // CSR bus widths.
    localparam int CSR_AW = 12;
    localparam int CSR_DW = 32;

    // First pmpcfg CSR, four entries per CSR, one byte each.
    localparam logic [CSR_AW-1:0] CSR_PMPCFG0 = 12'h3a0;

    // First pmpaddr CSR, one entry per CSR.
    localparam logic [CSR_AW-1:0] CSR_PMPADDR0 = 12'h3b0;

    // Address-matching modes.
    localparam logic [1:0] MODE_OFF   = 2'd0;
    localparam logic [1:0] MODE_TOR   = 2'd1;
    localparam logic [1:0] MODE_NA4   = 2'd2;
    localparam logic [1:0] MODE_NAPOT = 2'd3;

endpackage

/* rtl/pmp_region_match.sv */
// PMP single region match
`timescale 1ns/100ps

module pmp_region_match (
    input  logic [pmp_pkg::ENTRY_AW-1:0] addr,
    input  logic [1:0]                   entry_cfg_mode,
    input  logic [pmp_pkg::ENTRY_AW-1:0] entry_addr,
    input  logic [pmp_pkg::ENTRY_AW-1:0] base_addr,
    output logic                         contains
);

    // Trailing ones of the entry address, and the first zero above them.
    logic [pmp_pkg::ENTRY_AW-1:0] napot_mask;
    logic [pmp_pkg::ENTRY_AW-1:0] napot_bit;

    always_comb begin : napot_gen
        logic run;
        run = 1'b1;
        for (int i = 0; i < pmp_pkg::ENTRY_AW; i++) begin
            napot_mask[i] = run & entry_addr[i];
            napot_bit[i]  = run & ~entry_addr[i];
            run           = napot_mask[i];
        end
    end

    always_comb begin
        case (entry_cfg_mode)
            pmp_pkg::MODE_OFF: begin
                contains = 1'b0;
            end
            pmp_pkg::MODE_TOR: begin
                contains = (addr >= base_addr) && (addr < entry_addr);
            end
            pmp_pkg::MODE_NA4: begin
                contains = (pmp_pkg::GRAIN == 2) && (addr == entry_addr);
            end
            default: begin
                // Masked bits are don't-care, the rest must equal the base.
                contains = (addr | napot_mask | napot_bit) == (entry_addr | napot_bit);
            end
        endcase
    end

endmodule

/* rtl/pmp_access_check.sv */
// PMP access check port
`timescale 1ns/100ps

module pmp_access_check (
    input  logic [pmp_pkg::DEPTH*pmp_pkg::CFG_W-1:0]    entry_cfg,
    input  logic [pmp_pkg::DEPTH*pmp_pkg::ENTRY_AW-1:0] entry_addr,
    input  logic [pmp_pkg::DEPTH-1:0]                   entry_lock,
    input  logic [pmp_pkg::CHECK_AW-1:0]                addr,
    input  logic                                        m_mode,
    output logic                                        r,
    output logic                                        w,
    output logic                                        x
);

    // Checked address at entry granularity.
    logic [pmp_pkg::ENTRY_AW-1:0] grain_addr;

    logic [pmp_pkg::DEPTH-1:0]    contains;
    logic [pmp_pkg::DEPTH-1:0]    filtered;
    logic [pmp_pkg::DEPTH-1:0]    active;

    assign grain_addr = addr[pmp_pkg::CHECK_AW-1:pmp_pkg::GRAIN-2];

    for (genvar e = 0; e < pmp_pkg::DEPTH; e++) begin : g_region
        logic [pmp_pkg::ENTRY_AW-1:0] base;

        // TOR range starts at the previous entry, or at zero for entry 0.
        if (e == 0) begin : g_first
            assign base = '0;
        end else begin : g_next
            assign base = entry_addr[(e-1)*pmp_pkg::ENTRY_AW +: pmp_pkg::ENTRY_AW];
        end

        pmp_region_match u_match (
            .addr           (grain_addr),
            .entry_cfg_mode (entry_cfg[e*pmp_pkg::CFG_W+3 +: 2]),
            .entry_addr     (entry_addr[e*pmp_pkg::ENTRY_AW +: pmp_pkg::ENTRY_AW]),
            .base_addr      (base),
            .contains       (contains[e])
        );
    end

    // In M-mode only locked entries apply.
    assign filtered = contains & (~{pmp_pkg::DEPTH{m_mode}} | entry_lock);

    // Lowest-numbered surviving match wins.
    assign active = filtered & ~(filtered - pmp_pkg::DEPTH'(1));

    // M-mode keeps full access unless a locked entry matches.
    always_comb begin
        if (filtered == '0 && m_mode) begin
            r = 1'b1;
            w = 1'b1;
            x = 1'b1;
        end else begin
            r = 1'b0;
            w = 1'b0;
            x = 1'b0;
            for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
                r = r | (active[e] & entry_cfg[e*pmp_pkg::CFG_W + 0]);
                w = w | (active[e] & entry_cfg[e*pmp_pkg::CFG_W + 1]);
                x = x | (active[e] & entry_cfg[e*pmp_pkg::CFG_W + 2]);
            end
        end
    end

endmodule

/* rtl/pmp_entry_regs.sv */
// PMP entry register file
`timescale 1ns/100ps

module pmp_entry_regs (
    input  logic                                             clk,
    input  logic                                             rst,

    input  logic [pmp_pkg::CSR_AW-1:0]                       csr_addr,
    input  logic [pmp_pkg::CSR_DW-1:0]                       csr_wdata,
    input  logic                                             csr_we,
    output logic [pmp_pkg::CSR_DW-1:0]                       csr_rdata,
    output logic                                             csr_exists,

    output logic [pmp_pkg::DEPTH*pmp_pkg::CFG_W-1:0]         entry_cfg,
    output logic [pmp_pkg::DEPTH*pmp_pkg::ENTRY_AW-1:0]      entry_addr,
    output logic [pmp_pkg::DEPTH-1:0]                        entry_lock
);

    // Entry state.
    logic [pmp_pkg::CFG_W-1:0]    cfg_q  [pmp_pkg::DEPTH];
    logic [pmp_pkg::ENTRY_AW-1:0] addr_q [pmp_pkg::DEPTH];
    logic [pmp_pkg::DEPTH-1:0]    lock_q;

    // CSR decode.
    logic [pmp_pkg::CSR_AW-1:0]   cfg_off;
    logic [pmp_pkg::CSR_AW-1:0]   addr_off;
    logic [pmp_pkg::DEPTH-1:0]    cfg_hit;
    logic [pmp_pkg::DEPTH-1:0]    addr_hit;

    // Write-side helpers.
    logic [pmp_pkg::DEPTH-1:0]    wr_ok;
    logic [pmp_pkg::CFG_W-1:0]    cfg_new [pmp_pkg::DEPTH];
    logic [pmp_pkg::DEPTH-1:0]    lock_req;
    logic [pmp_pkg::ENTRY_AW-1:0] addr_new;

    // Read-side address value per entry.
    logic [pmp_pkg::CSR_DW-1:0]   addr_rd [pmp_pkg::DEPTH];

    // Offsets wrap for addresses below the base, so an equality check is enough.
    assign cfg_off  = csr_addr - pmp_pkg::CSR_PMPCFG0;
    assign addr_off = csr_addr - pmp_pkg::CSR_PMPADDR0;

    always_comb begin
        for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
            cfg_hit[e]  = (cfg_off == pmp_pkg::CSR_AW'(e / 4));
            addr_hit[e] = (addr_off == pmp_pkg::CSR_AW'(e));
        end
    end

    // An entry is frozen by its own lock or by a locked TOR entry above it.
    always_comb begin
        for (int e = 0; e < pmp_pkg::DEPTH - 1; e++) begin
            wr_ok[e] = !lock_q[e] &&
                       !(lock_q[e+1] && cfg_q[e+1][4:3] == pmp_pkg::MODE_TOR);
        end
        wr_ok[pmp_pkg::DEPTH-1] = !lock_q[pmp_pkg::DEPTH-1];
    end

    // Split the written cfg word into per-entry bytes.
    always_comb begin
        for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
            cfg_new[e]  = csr_wdata[8*(e%4) +: pmp_pkg::CFG_W];
            lock_req[e] = csr_wdata[8*(e%4) + 7];
            // NA4 cannot exist with a coarser grain.
            if (pmp_pkg::GRAIN > 2 && cfg_new[e][4:3] == pmp_pkg::MODE_NA4) begin
                cfg_new[e][4:3] = pmp_pkg::MODE_NAPOT;
            end
        end
    end

    assign addr_new = csr_wdata[pmp_pkg::ADDR_W-3:pmp_pkg::GRAIN-2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
                cfg_q[e]  <= '0;
                addr_q[e] <= '0;
            end
            lock_q <= '0;
        end else if (csr_we) begin
            for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
                if (cfg_hit[e]) begin
                    if (wr_ok[e]) begin
                        cfg_q[e] <= cfg_new[e];
                    end
                    // Lock is sticky until reset.
                    lock_q[e] <= lock_q[e] | lock_req[e];
                end
                if (addr_hit[e] && wr_ok[e]) begin
                    addr_q[e] <= addr_new;
                end
            end
        end
    end

    // Bits below the grain read as ones in NAPOT mode.
    always_comb begin
        for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
            addr_rd[e] = pmp_pkg::CSR_DW'(addr_q[e]) << (pmp_pkg::GRAIN - 2);
            if (cfg_q[e][4:3] == pmp_pkg::MODE_NAPOT) begin
                addr_rd[e] = addr_rd[e] |
                             ((pmp_pkg::CSR_DW'(1) << (pmp_pkg::GRAIN - 2)) - 1);
            end
        end
    end

    // Combinational CSR read.
    always_comb begin
        csr_rdata  = '0;
        csr_exists = 1'b0;
        for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
            if (cfg_hit[e]) begin
                csr_rdata[8*(e%4) +: 8] = {lock_q[e], {(7 - pmp_pkg::CFG_W){1'b0}}, cfg_q[e]};
                csr_exists = 1'b1;
            end
            if (addr_hit[e]) begin
                csr_rdata  = addr_rd[e];
                csr_exists = 1'b1;
            end
        end
    end

    // Flatten entry state for the check ports.
    always_comb begin
        for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
            entry_cfg[e*pmp_pkg::CFG_W +: pmp_pkg::CFG_W]        = cfg_q[e];
            entry_addr[e*pmp_pkg::ENTRY_AW +: pmp_pkg::ENTRY_AW] = addr_q[e];
        end
    end

    assign entry_lock = lock_q;

endmodule

/* rtl/pmp_unit.sv */
// PMP subsystem top
`timescale 1ns/100ps

module pmp_unit (
    input  logic                                           clk,
    input  logic                                           rst,

    // CSR access from the core.
    input  logic [pmp_pkg::CSR_AW-1:0]                     csr_addr,
    input  logic [pmp_pkg::CSR_DW-1:0]                     csr_wdata,
    input  logic                                           csr_we,
    output logic [pmp_pkg::CSR_DW-1:0]                     csr_rdata,
    output logic                                           csr_exists,

    // Access-check ports, flattened per port.
    input  logic [pmp_pkg::CHECKERS*pmp_pkg::CHECK_AW-1:0] check_addr,
    input  logic [pmp_pkg::CHECKERS-1:0]                   check_m_mode,
    output logic [pmp_pkg::CHECKERS-1:0]                   check_r,
    output logic [pmp_pkg::CHECKERS-1:0]                   check_w,
    output logic [pmp_pkg::CHECKERS-1:0]                   check_x
);

    logic [pmp_pkg::DEPTH*pmp_pkg::CFG_W-1:0]    entry_cfg;
    logic [pmp_pkg::DEPTH*pmp_pkg::ENTRY_AW-1:0] entry_addr;
    logic [pmp_pkg::DEPTH-1:0]                   entry_lock;

    pmp_entry_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .csr_we     (csr_we),
        .csr_rdata  (csr_rdata),
        .csr_exists (csr_exists),
        .entry_cfg  (entry_cfg),
        .entry_addr (entry_addr),
        .entry_lock (entry_lock)
    );

    // All ports share the same entry state.
    for (genvar k = 0; k < pmp_pkg::CHECKERS; k++) begin : g_check
        pmp_access_check u_check (
            .entry_cfg  (entry_cfg),
            .entry_addr (entry_addr),
            .entry_lock (entry_lock),
            .addr       (check_addr[k*pmp_pkg::CHECK_AW +: pmp_pkg::CHECK_AW]),
            .m_mode     (check_m_mode[k]),
            .r          (check_r[k]),
            .w          (check_w[k]),
            .x          (check_x[k])
        );
    end

endmodule

/* bench/pmp_model.svh */
// PMP reference model
`ifndef PMP_MODEL_SVH
`define PMP_MODEL_SVH

// Shadow entry state.
logic [pmp_pkg::CFG_W-1:0]    m_cfg  [pmp_pkg::DEPTH];
logic [pmp_pkg::ENTRY_AW-1:0] m_addr [pmp_pkg::DEPTH];
logic                         m_lock [pmp_pkg::DEPTH];

function automatic void model_reset();
    for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
        m_cfg[e]  = '0;
        m_addr[e] = '0;
        m_lock[e] = 1'b0;
    end
endfunction

// Frozen by its own lock or by a locked TOR entry just above.
function automatic logic model_writable(int e);
    if (m_lock[e]) begin
        return 1'b0;
    end
    if (e + 1 < pmp_pkg::DEPTH) begin
        if (m_lock[e+1] && m_cfg[e+1][4:3] == pmp_pkg::MODE_TOR) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

function automatic void model_csr_write(logic [pmp_pkg::CSR_AW-1:0] a,
                                        logic [pmp_pkg::CSR_DW-1:0] d);
    logic wr [pmp_pkg::DEPTH];
    int   cfg_idx;
    int   addr_idx;
    int   e;
    cfg_idx  = int'(a) - int'(pmp_pkg::CSR_PMPCFG0);
    addr_idx = int'(a) - int'(pmp_pkg::CSR_PMPADDR0);
    // Writeability comes from the state before this write.
    for (int i = 0; i < pmp_pkg::DEPTH; i++) begin
        wr[i] = model_writable(i);
    end
    if (cfg_idx >= 0 && cfg_idx < pmp_pkg::DEPTH / 4) begin
        for (int j = 0; j < 4; j++) begin
            e = 4 * cfg_idx + j;
            if (wr[e]) begin
                m_cfg[e] = d[8*j +: pmp_pkg::CFG_W];
                if (pmp_pkg::GRAIN > 2 && m_cfg[e][4:3] == pmp_pkg::MODE_NA4) begin
                    m_cfg[e][4:3] = pmp_pkg::MODE_NAPOT;
                end
            end
            m_lock[e] = m_lock[e] | d[8*j+7];
        end
    end
    if (addr_idx >= 0 && addr_idx < pmp_pkg::DEPTH && wr[addr_idx]) begin
        m_addr[addr_idx] = d[pmp_pkg::ADDR_W-3:pmp_pkg::GRAIN-2];
    end
endfunction

function automatic void model_csr_read(input  logic [pmp_pkg::CSR_AW-1:0] a,
                                       output logic [pmp_pkg::CSR_DW-1:0] d,
                                       output logic                       exists);
    int cfg_idx;
    int addr_idx;
    int e;
    cfg_idx  = int'(a) - int'(pmp_pkg::CSR_PMPCFG0);
    addr_idx = int'(a) - int'(pmp_pkg::CSR_PMPADDR0);
    d      = '0;
    exists = 1'b0;
    if (cfg_idx >= 0 && cfg_idx < pmp_pkg::DEPTH / 4) begin
        exists = 1'b1;
        for (int j = 0; j < 4; j++) begin
            e = 4 * cfg_idx + j;
            d[8*j +: pmp_pkg::CFG_W] = m_cfg[e];
            d[8*j+7] = m_lock[e];
        end
    end
    if (addr_idx >= 0 && addr_idx < pmp_pkg::DEPTH) begin
        exists = 1'b1;
        d = '0;
        d[pmp_pkg::ADDR_W-3:pmp_pkg::GRAIN-2] = m_addr[addr_idx];
        // NAPOT reads the bits below the grain as ones.
        if (m_cfg[addr_idx][4:3] == pmp_pkg::MODE_NAPOT) begin
            for (int b = 0; b < pmp_pkg::GRAIN - 2; b++) begin
                d[b] = 1'b1;
            end
        end
    end
endfunction

function automatic logic model_match(int e, logic [pmp_pkg::ENTRY_AW-1:0] ga);
    logic [pmp_pkg::ENTRY_AW-1:0] base;
    int t;
    base = '0;
    t    = 0;
    case (m_cfg[e][4:3])
        pmp_pkg::MODE_TOR: begin
            if (e > 0) begin
                base = m_addr[e-1];
            end
            return (ga >= base) && (ga < m_addr[e]);
        end
        pmp_pkg::MODE_NA4: begin
            return (pmp_pkg::GRAIN == 2) && (ga == m_addr[e]);
        end
        pmp_pkg::MODE_NAPOT: begin
            // Region of 2^(t+1) grains where t counts the trailing ones.
            while (t < pmp_pkg::ENTRY_AW && m_addr[e][t]) begin
                t++;
            end
            return (ga >> (t + 1)) == (m_addr[e] >> (t + 1));
        end
        default: begin
            return 1'b0;
        end
    endcase
endfunction

function automatic void model_check(input  logic [pmp_pkg::CHECK_AW-1:0] a,
                                    input  logic m,
                                    output logic r, output logic w, output logic x);
    logic [pmp_pkg::ENTRY_AW-1:0] ga;
    logic found;
    ga    = pmp_pkg::ENTRY_AW'(a >> (pmp_pkg::GRAIN - 2));
    found = 1'b0;
    {r, w, x} = 3'b000;
    for (int e = 0; e < pmp_pkg::DEPTH; e++) begin
        if (model_match(e, ga)) begin
            if (!found && (!m || m_lock[e])) begin
                found = 1'b1;
                r = m_cfg[e][0];
                w = m_cfg[e][1];
                x = m_cfg[e][2];
            end
        end
    end
    // Unlocked matches leave M-mode unrestricted.
    if (!found && m) begin
        {r, w, x} = 3'b111;
    end
endfunction

`endif

/* bench/pmp_tb.sv */
// PMP unit testbench
`timescale 1ns/100ps

module pmp_tb;

    localparam int CAW = pmp_pkg::CHECK_AW;
    // Roughly twice the cycles that all tests need.
    localparam int MAX_CYCLES = 4000;

    logic                             clk;
    logic                             rst;
    logic [pmp_pkg::CSR_AW-1:0]       csr_addr;
    logic [pmp_pkg::CSR_DW-1:0]       csr_wdata;
    logic                             csr_we;
    logic [pmp_pkg::CSR_DW-1:0]       csr_rdata;
    logic                             csr_exists;
    logic [pmp_pkg::CHECKERS*CAW-1:0] check_addr;
    logic [pmp_pkg::CHECKERS-1:0]     check_m_mode;
    logic [pmp_pkg::CHECKERS-1:0]     check_r;
    logic [pmp_pkg::CHECKERS-1:0]     check_w;
    logic [pmp_pkg::CHECKERS-1:0]     check_x;

    // Results the compare process looks at this cycle.
    logic csr_pending;
    logic perm_pending;
    int   seed;
    int   cycle_count = 0;
    int   err_count = 0;
    int   test_start_errs;
    int   tests_passed;
    int   tests_failed;

    `include "pmp_model.svh"

    pmp_unit DUT (
        .clk          (clk),
        .rst          (rst),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .csr_we       (csr_we),
        .csr_rdata    (csr_rdata),
        .csr_exists   (csr_exists),
        .check_addr   (check_addr),
        .check_m_mode (check_m_mode),
        .check_r      (check_r),
        .check_w      (check_w),
        .check_x      (check_x)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic check_csr(input logic [pmp_pkg::CSR_DW-1:0] got, input logic got_exists,
                             input logic [pmp_pkg::CSR_DW-1:0] exp, input logic exp_exists);
        if (got !== exp || got_exists !== exp_exists) begin
            $display("Error at %0t: CSR 0x%03h read %08h exists %0b, expected %08h exists %0b",
                     $time, csr_addr, got, got_exists, exp, exp_exists);
            err_count++;
        end
    endtask

    // Permission bits in x, w, r order.
    task automatic check_perm(input int port, input logic [CAW-1:0] a, input logic m,
                              input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: port %0d addr %08h m_mode %0b gave xwr %03b, expected %03b",
                     $time, port, a, m, got, exp);
            err_count++;
        end
    endtask

    // Outputs are sampled mid-cycle, well after the inputs settle.
    always @(negedge clk) begin : compare
        logic [pmp_pkg::CSR_DW-1:0] exp_data;
        logic                       exp_exists;
        logic                       er;
        logic                       ew;
        logic                       ex;
        if (csr_pending) begin
            model_csr_read(csr_addr, exp_data, exp_exists);
            check_csr(csr_rdata, csr_exists, exp_data, exp_exists);
        end
        if (perm_pending) begin
            for (int k = 0; k < pmp_pkg::CHECKERS; k++) begin
                model_check(check_addr[k*CAW +: CAW], check_m_mode[k], er, ew, ex);
                check_perm(k, check_addr[k*CAW +: CAW], check_m_mode[k],
                           {check_x[k], check_w[k], check_r[k]}, {ex, ew, er});
            end
        end
    end

    task automatic settle();
        @(posedge clk);
        #1;
        csr_we       = 1'b0;
        csr_pending  = 1'b0;
        perm_pending = 1'b0;
    endtask

    task automatic do_reset();
        settle();
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        model_reset();
    endtask

    task automatic csr_write(input logic [pmp_pkg::CSR_AW-1:0] a,
                             input logic [pmp_pkg::CSR_DW-1:0] d);
        settle();
        csr_addr  = a;
        csr_wdata = d;
        csr_we    = 1'b1;
        model_csr_write(a, d);
    endtask

    task automatic csr_read(input logic [pmp_pkg::CSR_AW-1:0] a);
        settle();
        csr_addr    = a;
        csr_pending = 1'b1;
    endtask

    task automatic perm_probe(input logic [CAW-1:0] a0, input logic [CAW-1:0] a1,
                              input logic m0, input logic m1);
        settle();
        check_addr   = {a1, a0};
        check_m_mode = {m1, m0};
        perm_pending = 1'b1;
    endtask

    task automatic read_all_csrs();
        for (int i = 0; i < pmp_pkg::DEPTH / 4; i++) begin
            csr_read(pmp_pkg::CSR_PMPCFG0 + 12'(i));
        end
        for (int i = 0; i < pmp_pkg::DEPTH; i++) begin
            csr_read(pmp_pkg::CSR_PMPADDR0 + 12'(i));
        end
    endtask

    task automatic finish_test(input string name);
        settle();
        if (err_count == test_start_errs) begin
            $display("Test %s: passed", name);
            tests_passed++;
        end else begin
            $display("Test %s: failed with %0d mismatches", name, err_count - test_start_errs);
            tests_failed++;
        end
        test_start_errs = err_count;
    endtask

    initial begin
        logic [CAW-1:0] lo;
        logic [CAW-1:0] hi;
        logic [CAW-1:0] mask;
        logic [31:0]    r;
        logic [31:0]    cfg_word;
        logic [1:0]     mode;
        logic           pm;
        int             e;
        int             k;
        seed = 32'h8ed8;
        clk = 1'b0;
        rst = 1'b1;
        csr_addr = '0;
        csr_wdata = '0;
        csr_we = 1'b0;
        check_addr = '0;
        check_m_mode = '0;
        csr_pending = 1'b0;
        perm_pending = 1'b0;
        test_start_errs = 0;
        tests_passed = 0;
        tests_failed = 0;
        do_reset();

        read_all_csrs();
        csr_read(12'h3a4);
        csr_read(12'h3c0);
        for (int i = 0; i < 8; i++) begin
            perm_probe(CAW'(next_random()), CAW'(next_random()), i[0], !i[0]);
        end
        finish_test("1 reset state");

        do_reset();
        for (int pass = 0; pass < 2; pass++) begin
            // Second pass clears the lock bits, which must stay set.
            for (int i = 0; i < pmp_pkg::DEPTH / 4; i++) begin
                csr_write(pmp_pkg::CSR_PMPCFG0 + 12'(i),
                          next_random() & (pass == 0 ? 32'hffffffff : 32'h7f7f7f7f));
            end
            for (int i = 0; i < pmp_pkg::DEPTH; i++) begin
                csr_write(pmp_pkg::CSR_PMPADDR0 + 12'(i), next_random());
            end
        end
        read_all_csrs();
        finish_test("2 CSR write and read back");

        for (int it = 0; it < 300; it++) begin
            if (it % 25 == 0) begin
                do_reset();
            end
            r    = next_random();
            e    = int'(r % pmp_pkg::DEPTH);
            mode = 2'(1 + (r >> 8) % 3);
            k    = int'((r >> 12) % 16);
            lo   = '0;
            if (mode == pmp_pkg::MODE_TOR) begin
                if (e > 0) begin
                    lo = CAW'(m_addr[e-1]);
                end
                hi = lo + CAW'((r >> 12) % 256);
                csr_write(pmp_pkg::CSR_PMPADDR0 + 12'(e), 32'(hi + CAW'(1)));
            end else if (mode == pmp_pkg::MODE_NA4) begin
                lo = CAW'(next_random());
                hi = lo;
                csr_write(pmp_pkg::CSR_PMPADDR0 + 12'(e), 32'(lo));
            end else begin
                mask = (CAW'(1) << (k + 1)) - CAW'(1);
                lo   = CAW'(next_random()) & ~mask;
                hi   = lo | mask;
                csr_write(pmp_pkg::CSR_PMPADDR0 + 12'(e), 32'(lo | (mask >> 1)));
            end
            // Roughly one region in eight is locked.
            cfg_word = next_random() & 32'h7f7f7f7f;
            cfg_word[8*(e%4) +: 8] = {(r[20:18] == 3'd0), 2'b00, mode, r[23:21]};
            csr_write(pmp_pkg::CSR_PMPCFG0 + 12'(e / 4), cfg_word);
            pm = r[24];
            perm_probe(lo, lo, pm, !pm);
            perm_probe(hi, hi, !pm, pm);
            perm_probe(hi + CAW'(1), lo - CAW'(1), pm, !pm);
            r = next_random();
            perm_probe(CAW'(next_random()), CAW'(r), r[0], r[1]);
        end
        finish_test("3 random regions");

        // Entry 2 is a small read-only region inside the larger rwx region of entry 5.
        do_reset();
        csr_write(pmp_pkg::CSR_PMPADDR0 + 12'd2, 32'h0000_107f);
        csr_write(pmp_pkg::CSR_PMPADDR0 + 12'd5, 32'h0000_17ff);
        csr_write(pmp_pkg::CSR_PMPCFG0, 32'h0019_0000);
        csr_write(pmp_pkg::CSR_PMPCFG0 + 12'd1, 32'h0000_1f00);
        perm_probe(CAW'('h1010), CAW'('h1010), 1'b0, 1'b1);
        perm_probe(CAW'('h1800), CAW'('h1800), 1'b0, 1'b1);
        perm_probe(CAW'('h3000), CAW'('h10ff), 1'b1, 1'b0);
        finish_test("4 priority");

        // Entry 3 is a locked read-only TOR range, entry 6 an unlocked x-only NAPOT.
        do_reset();
        csr_write(pmp_pkg::CSR_PMPADDR0 + 12'd2, 32'h0000_2000);
        csr_write(pmp_pkg::CSR_PMPADDR0 + 12'd3, 32'h0000_2100);
        csr_write(pmp_pkg::CSR_PMPADDR0 + 12'd6, 32'h0000_407f);
        csr_write(pmp_pkg::CSR_PMPCFG0 + 12'd1, 32'h001c_0000);
        csr_write(pmp_pkg::CSR_PMPCFG0, 32'h8900_0000);
        csr_write(pmp_pkg::CSR_PMPADDR0 + 12'd3, 32'h0000_5555);
        csr_write(pmp_pkg::CSR_PMPADDR0 + 12'd2, 32'h0000_0000);
        csr_write(pmp_pkg::CSR_PMPCFG0, 32'h1f1f_1f1f);
        csr_read(pmp_pkg::CSR_PMPCFG0);
        csr_read(pmp_pkg::CSR_PMPADDR0 + 12'd2);
        csr_read(pmp_pkg::CSR_PMPADDR0 + 12'd3);
        perm_probe(CAW'('h2050), CAW'('h2050), 1'b1, 1'b0);
        perm_probe(CAW'('h4010), CAW'('h4010), 1'b1, 1'b0);
        perm_probe(CAW'('h8000), CAW'('h20ff), 1'b1, 1'b1);
        finish_test("5 locking");

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+bench
rtl/pmp_pkg.sv
rtl/pmp_region_match.sv
rtl/pmp_access_check.sv
rtl/pmp_entry_regs.sv
rtl/pmp_unit.sv
bench/pmp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PMP testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f tb.f --top-module pmp_tb \
    -Mdir obj_dir -o pmp_sim

./obj_dir/pmp_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1
